// File: verilog/game_pkg.sv
package game_pkg;

	localparam int coord_width = 16;
	localparam int velocity_width = 16;
	localparam int frame_count_width = 8;

	typedef logic [coord_width-1:0] coord_t;
	typedef logic signed [velocity_width-1:0] velocity_t;

	// Screen coordinates, y grows downward
	typedef struct packed {
		coord_t x; // Upper half of the bus word
		coord_t y;
	} position_t;

	typedef struct packed {
		coord_t width;
		coord_t height;
	} box_size_t;

	// Controller buttons, held levels
	typedef struct packed {
		logic left;
		logic right;
		logic jump;
		logic attack;
	} pad_t;

	typedef struct packed {
		logic offstage; // No horizontal overlap with the stage
		logic grounded; // Standing on the stage top
	} coll_t;

	typedef struct packed {
		logic active;
		logic facing_right;
		logic hit_done; // Already struck during this attack
		logic [frame_count_width-1:0] frames_left;
	} attack_state_t;

endpackage

// File: verilog/bus_pkg.sv
package bus_pkg;

	typedef logic [31:0] word_t;

	// Region bit clear selects data memory
	typedef struct packed {
		logic coprocessor;
		logic [11:0] index;
	} mem_view_t;

	typedef struct packed {
		logic coprocessor;
		logic [4:0] unit;
		logic [6:0] offset; // Not decoded
	} copro_view_t;

	typedef union packed {
		mem_view_t mem;
		copro_view_t copro;
	} mmio_addr_t;

	// One word per unit
	typedef enum logic [4:0] {
		unit_pos_p1 = 5'd0,
		unit_pos_p2 = 5'd1,
		unit_pad_p1 = 5'd4,
		unit_pad_p2 = 5'd5,
		unit_coll_p1 = 5'd12,
		unit_coll_p2 = 5'd13,
		unit_attack_p1 = 5'd16,
		unit_attack_p2 = 5'd17,
		unit_damage_p1 = 5'd24, // Dealt by p2
		unit_damage_p2 = 5'd25, // Dealt by p1
		unit_size_p1 = 5'd26,
		unit_size_p2 = 5'd27
	} unit_t;

endpackage

// File: verilog/physics_coprocessor.sv
`timescale 1ns/1ps

module physics_coprocessor #(
	parameter game_pkg::position_t start_pos = '{x: 16'd0, y: 16'd0},
	parameter int walk_step = 4,
	parameter int jump_speed = 12,
	parameter int gravity_step = 1,
	parameter int knock_distance = 16
) (
	input logic clock,
	input logic reset,
	input logic frame,
	input game_pkg::pad_t pad,
	input game_pkg::coll_t coll,
	input logic frozen, // Own attack running
	input logic knock, // Opponent hit pulse
	input logic knock_right,
	output game_pkg::position_t position
);

	game_pkg::velocity_t speed;
	game_pkg::velocity_t fall_speed;
	logic knock_pending;
	logic knock_dir;
	logic knock_now;
	logic knock_dir_now;
	game_pkg::coord_t walked_x;
	game_pkg::coord_t next_x;

	// A pulse arriving on the frame cycle itself still counts
	assign knock_now = knock_pending | knock;
	assign knock_dir_now = knock ? knock_right : knock_dir;

	assign fall_speed = speed + game_pkg::velocity_t'(gravity_step);

	always_comb begin
		walked_x = position.x;
		if (pad.right && !pad.left)
			walked_x = position.x + game_pkg::coord_t'(walk_step);
		else if (pad.left && !pad.right)
			walked_x = position.x - game_pkg::coord_t'(walk_step);

		// Knockback pushes away from the attacker
		next_x = walked_x;
		if (knock_now) begin
			if (knock_dir_now)
				next_x = walked_x + game_pkg::coord_t'(knock_distance);
			else
				next_x = walked_x - game_pkg::coord_t'(knock_distance);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			position <= start_pos;
			speed <= '0;
			knock_pending <= 1'b0;
			knock_dir <= 1'b0;
		end else begin
			if (knock) begin
				knock_pending <= 1'b1; // Held until the next unfrozen frame
				knock_dir <= knock_right;
			end
			if (frame && !frozen) begin
				position.x <= next_x;
				knock_pending <= 1'b0;
				if (coll.grounded) begin
					if (pad.jump) begin
						speed <= -game_pkg::velocity_t'(jump_speed);
						position.y <= position.y - game_pkg::coord_t'(jump_speed);
					end else begin
						speed <= '0;
					end
				end else begin
					// Airborne, accelerate first then move
					speed <= fall_speed;
					position.y <= position.y + game_pkg::coord_t'(fall_speed);
				end
			end
		end
	end

	// Both direction buttons cancel, so only a knock may move x then
	assert property (@(posedge clock) disable iff (reset)
		frame && !frozen && pad.left && pad.right && !knock_now |=> $stable(position.x));

endmodule

// File: verilog/stage_collision.sv
`timescale 1ns/1ps

module stage_collision #(
	parameter game_pkg::position_t stage_pos = '{x: 16'd0, y: 16'd0},
	parameter game_pkg::box_size_t stage_size = '{width: 16'd0, height: 16'd0}
) (
	input game_pkg::position_t position,
	input game_pkg::box_size_t size,
	output game_pkg::coll_t coll
);

	// One extra bit so edges past 65535 still compare right
	logic [16:0] player_left;
	logic [16:0] player_right;
	logic [16:0] player_bottom;
	logic [16:0] stage_left;
	logic [16:0] stage_right;
	logic [16:0] stage_top;
	logic overlap_x;

	assign player_left = {1'b0, position.x};
	assign player_right = {1'b0, position.x} + {1'b0, size.width};
	assign player_bottom = {1'b0, position.y} + {1'b0, size.height};

	assign stage_left = {1'b0, stage_pos.x};
	assign stage_right = {1'b0, stage_pos.x} + {1'b0, stage_size.width};
	assign stage_top = {1'b0, stage_pos.y};

	// Half-open spans [x, x + width)
	assign overlap_x = (player_left < stage_right) && (player_right > stage_left);

	assign coll.offstage = !overlap_x;

	// Feet at or below the stage top while the head is still above it
	assign coll.grounded = overlap_x && (player_bottom >= stage_top) &&
		({1'b0, position.y} < stage_top);

endmodule

// File: verilog/attack_coprocessor.sv
`timescale 1ns/1ps

module attack_coprocessor #(
	parameter logic start_facing = 1'b1,
	parameter int attack_frames = 6,
	parameter int attack_reach = 20,
	parameter int damage_per_hit = 7
) (
	input logic clock,
	input logic reset,
	input logic frame,
	input game_pkg::pad_t pad,
	input game_pkg::position_t own_position,
	input game_pkg::box_size_t own_size,
	input game_pkg::position_t foe_position,
	input game_pkg::box_size_t foe_size,
	output game_pkg::attack_state_t state,
	output logic hit,
	output bus_pkg::word_t damage_dealt
);

	// Horizontal edges are shifted up by attack_reach so nothing goes negative
	logic [17:0] reach_left;
	logic [17:0] reach_right;
	logic [17:0] foe_left;
	logic [17:0] foe_right;
	logic [17:0] own_top;
	logic [17:0] own_bottom;
	logic [17:0] foe_top;
	logic [17:0] foe_bottom;
	logic reach_overlap;

	assign reach_left = state.facing_right ? 18'(own_position.x) + 18'(attack_reach) :
		18'(own_position.x);
	assign reach_right = 18'(own_position.x) + 18'(own_size.width) + 18'(attack_reach) +
		(state.facing_right ? 18'(attack_reach) : 18'd0);
	assign foe_left = 18'(foe_position.x) + 18'(attack_reach);
	assign foe_right = 18'(foe_position.x) + 18'(foe_size.width) + 18'(attack_reach);

	assign own_top = 18'(own_position.y);
	assign own_bottom = 18'(own_position.y) + 18'(own_size.height);
	assign foe_top = 18'(foe_position.y);
	assign foe_bottom = 18'(foe_position.y) + 18'(foe_size.height);

	assign reach_overlap = (reach_left < foe_right) && (reach_right > foe_left) &&
		(own_top < foe_bottom) && (own_bottom > foe_top);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= '{active: 1'b0, facing_right: start_facing, hit_done: 1'b0,
				frames_left: '0};
			hit <= 1'b0;
			damage_dealt <= '0;
		end else begin
			hit <= 1'b0; // One cycle pulse
			if (frame) begin
				if (pad.left ^ pad.right)
					state.facing_right <= pad.right;
				if (!state.active) begin
					if (pad.attack) begin
						state.active <= 1'b1;
						state.frames_left <= game_pkg::frame_count_width'(attack_frames);
					end
				end else begin
					if (!state.hit_done && reach_overlap) begin
						hit <= 1'b1;
						damage_dealt <= damage_dealt + bus_pkg::word_t'(damage_per_hit);
						state.hit_done <= 1'b1;
					end
					// Last frame of the attack overrides the hit_done set above
					if (state.frames_left <= 1) begin
						state.active <= 1'b0;
						state.hit_done <= 1'b0;
						state.frames_left <= '0;
					end else begin
						state.frames_left <= state.frames_left - 1'b1;
					end
				end
			end
		end
	end

	// A strike comes only from a running attack that had not landed yet
	assert property (@(posedge clock) disable iff (reset)
		hit |-> $past(state.active && !state.hit_done));

endmodule

// File: verilog/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
	parameter int mem_depth = 4096
) (
	input logic clock,
	input logic write,
	input logic [11:0] index,
	input bus_pkg::word_t write_data,
	output bus_pkg::word_t read_data
);

	bus_pkg::word_t mem [mem_depth];

	// Read returns the old word when the same index is written
	always_ff @(posedge clock) begin
		if (write)
			mem[index] <= write_data;
		read_data <= mem[index];
	end

endmodule

// File: verilog/mmio.sv
`timescale 1ns/1ps

module mmio #(
	parameter game_pkg::position_t start_pos_p1 = '{x: 16'd352, y: 16'd100},
	parameter game_pkg::position_t start_pos_p2 = '{x: 16'd681, y: 16'd100},
	parameter game_pkg::box_size_t start_size = '{width: 16'd32, height: 16'd40},
	parameter game_pkg::position_t stage_pos = '{x: 16'd344, y: 16'd200},
	parameter game_pkg::box_size_t stage_size = '{width: 16'd460, height: 16'd110},
	parameter int walk_step = 4,
	parameter int jump_speed = 12,
	parameter int gravity_step = 1,
	parameter int knock_distance = 16,
	parameter int attack_frames = 6,
	parameter int attack_reach = 20,
	parameter int damage_per_hit = 7,
	parameter int mem_depth = 4096,
	parameter logic start_facing_p1 = 1'b1,
	parameter logic start_facing_p2 = 1'b0
) (
	input logic clock,
	input logic reset,
	input bus_pkg::mmio_addr_t address,
	input bus_pkg::word_t write_data,
	input logic write,
	input logic frame,
	input game_pkg::pad_t pad_p1,
	input game_pkg::pad_t pad_p2,
	output bus_pkg::word_t read_data
);

	bus_pkg::unit_t unit;
	logic mem_write;
	logic copro_write;
	game_pkg::box_size_t size_p1;
	game_pkg::box_size_t size_p2;
	game_pkg::position_t position_p1;
	game_pkg::position_t position_p2;
	game_pkg::coll_t coll_p1;
	game_pkg::coll_t coll_p2;
	game_pkg::attack_state_t attack_p1;
	game_pkg::attack_state_t attack_p2;
	logic hit_p1; // Struck by p1
	logic hit_p2;
	bus_pkg::word_t dealt_p1;
	bus_pkg::word_t dealt_p2;
	bus_pkg::word_t unit_word;
	logic unit_mapped;
	bus_pkg::word_t copro_word_q;
	logic region_q;
	bus_pkg::word_t mem_word;

	assign unit = bus_pkg::unit_t'(address.copro.unit);
	assign mem_write = write && !address.mem.coprocessor;
	assign copro_write = write && address.copro.coprocessor;

	// Box sizes, the only writable coprocessor words
	always_ff @(posedge clock) begin
		if (reset) begin
			size_p1 <= start_size;
			size_p2 <= start_size;
		end else if (copro_write) begin
			if (unit == bus_pkg::unit_size_p1)
				size_p1 <= game_pkg::box_size_t'(write_data);
			if (unit == bus_pkg::unit_size_p2)
				size_p2 <= game_pkg::box_size_t'(write_data);
		end
	end

	physics_coprocessor #(.start_pos(start_pos_p1), .walk_step(walk_step),
		.jump_speed(jump_speed), .gravity_step(gravity_step),
		.knock_distance(knock_distance)) u_physics_p1 (
		.clock(clock), .reset(reset), .frame(frame), .pad(pad_p1), .coll(coll_p1),
		.frozen(attack_p1.active), .knock(hit_p2), .knock_right(attack_p2.facing_right),
		.position(position_p1));

	physics_coprocessor #(.start_pos(start_pos_p2), .walk_step(walk_step),
		.jump_speed(jump_speed), .gravity_step(gravity_step),
		.knock_distance(knock_distance)) u_physics_p2 (
		.clock(clock), .reset(reset), .frame(frame), .pad(pad_p2), .coll(coll_p2),
		.frozen(attack_p2.active), .knock(hit_p1), .knock_right(attack_p1.facing_right),
		.position(position_p2));

	stage_collision #(.stage_pos(stage_pos), .stage_size(stage_size)) u_coll_p1 (
		.position(position_p1), .size(size_p1), .coll(coll_p1));

	stage_collision #(.stage_pos(stage_pos), .stage_size(stage_size)) u_coll_p2 (
		.position(position_p2), .size(size_p2), .coll(coll_p2));

	attack_coprocessor #(.start_facing(start_facing_p1), .attack_frames(attack_frames),
		.attack_reach(attack_reach), .damage_per_hit(damage_per_hit)) u_attack_p1 (
		.clock(clock), .reset(reset), .frame(frame), .pad(pad_p1),
		.own_position(position_p1), .own_size(size_p1),
		.foe_position(position_p2), .foe_size(size_p2),
		.state(attack_p1), .hit(hit_p1), .damage_dealt(dealt_p1));

	attack_coprocessor #(.start_facing(start_facing_p2), .attack_frames(attack_frames),
		.attack_reach(attack_reach), .damage_per_hit(damage_per_hit)) u_attack_p2 (
		.clock(clock), .reset(reset), .frame(frame), .pad(pad_p2),
		.own_position(position_p2), .own_size(size_p2),
		.foe_position(position_p1), .foe_size(size_p1),
		.state(attack_p2), .hit(hit_p2), .damage_dealt(dealt_p2));

	data_memory #(.mem_depth(mem_depth)) u_data_memory (
		.clock(clock), .write(mem_write), .index(address.mem.index),
		.write_data(write_data), .read_data(mem_word));

	// Coprocessor read mux, unmapped units read zero
	always_comb begin
		unit_word = '0;
		unit_mapped = 1'b1;
		case (unit)
			bus_pkg::unit_pos_p1: unit_word = bus_pkg::word_t'(position_p1);
			bus_pkg::unit_pos_p2: unit_word = bus_pkg::word_t'(position_p2);
			bus_pkg::unit_pad_p1: unit_word = bus_pkg::word_t'(pad_p1);
			bus_pkg::unit_pad_p2: unit_word = bus_pkg::word_t'(pad_p2);
			bus_pkg::unit_coll_p1: unit_word = bus_pkg::word_t'(coll_p1);
			bus_pkg::unit_coll_p2: unit_word = bus_pkg::word_t'(coll_p2);
			bus_pkg::unit_attack_p1: unit_word = bus_pkg::word_t'(attack_p1);
			bus_pkg::unit_attack_p2: unit_word = bus_pkg::word_t'(attack_p2);
			bus_pkg::unit_damage_p1: unit_word = dealt_p2; // p1 takes p2's hits
			bus_pkg::unit_damage_p2: unit_word = dealt_p1;
			bus_pkg::unit_size_p1: unit_word = bus_pkg::word_t'(size_p1);
			bus_pkg::unit_size_p2: unit_word = bus_pkg::word_t'(size_p2);
			default: unit_mapped = 1'b0;
		endcase
	end

	// Match the memory's one cycle read latency
	always_ff @(posedge clock) begin
		copro_word_q <= unit_word;
	end

	always_ff @(posedge clock) begin
		if (reset)
			region_q <= 1'b0;
		else
			region_q <= address.copro.coprocessor;
	end

	assign read_data = region_q ? copro_word_q : mem_word;

	// Processor only writes units in the map
	assert property (@(posedge clock) disable iff (reset) copro_write |-> unit_mapped);

endmodule

// File: test/mmio_tb.sv
`timescale 1ns/1ps

module mmio_tb;

	typedef struct packed {
		logic [7:0] count; // Times the row is applied
		game_pkg::pad_t pad1;
		game_pkg::pad_t pad2;
		logic frame;
		logic write;
		logic [12:0] address;
		bus_pkg::word_t data;
		logic check; // Compare read_data after the last application
		bus_pkg::word_t expected;
	} step_t;

	logic clock;
	logic reset;
	bus_pkg::mmio_addr_t address;
	bus_pkg::word_t write_data;
	logic write;
	logic frame;
	game_pkg::pad_t pad_p1;
	game_pkg::pad_t pad_p2;
	bus_pkg::word_t read_data;

	step_t steps [$];
	bus_pkg::word_t model_mem [4096]; // What the memory should hold
	logic [31:0] random_state;
	int table_cycles;
	int cycle_limit;
	int cycle_count;

	mmio u_mmio (.clock(clock), .reset(reset), .address(address), .write_data(write_data),
		.write(write), .frame(frame), .pad_p1(pad_p1), .pad_p2(pad_p2),
		.read_data(read_data));

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic logic [31:0] next_random();
		random_state = random_state * 32'd1664525 + 32'd1013904223;
		return random_state;
	endfunction

	function automatic logic [12:0] copro_addr(input logic [4:0] unit);
		return {1'b1, unit, 7'd0};
	endfunction

	function automatic void push_step(input int count, input logic [3:0] pad1,
		input logic [3:0] pad2, input logic frame_bit, input logic write_bit,
		input logic [12:0] addr, input bus_pkg::word_t data, input logic check,
		input bus_pkg::word_t expected);
		step_t s;
		s.count = 8'(count);
		s.pad1 = game_pkg::pad_t'(pad1);
		s.pad2 = game_pkg::pad_t'(pad2);
		s.frame = frame_bit;
		s.write = write_bit;
		s.address = addr;
		s.data = data;
		s.check = check;
		s.expected = expected;
		steps.push_back(s);
		table_cycles += count * (frame_bit ? 2 : 1); // Frames get a quiet cycle after
	endfunction

	function automatic void queue_read(input logic [4:0] unit, input bus_pkg::word_t expected);
		push_step(1, 4'h0, 4'h0, 1'b0, 1'b0, copro_addr(unit), '0, 1'b1, expected);
	endfunction

	function automatic void queue_write(input logic [12:0] addr, input bus_pkg::word_t data);
		push_step(1, 4'h0, 4'h0, 1'b0, 1'b1, addr, data, 1'b0, '0);
	endfunction

	function automatic void queue_frames(input int count, input logic [3:0] pad1,
		input logic [3:0] pad2);
		push_step(count, pad1, pad2, 1'b1, 1'b0, copro_addr(bus_pkg::unit_pos_p1), '0, 1'b0,
			'0);
	endfunction

	function automatic void build_memory_rows();
		logic [11:0] written [$];
		logic [11:0] index;
		bus_pkg::word_t data;
		for (int i = 0; i < 16; i++) begin
			data = next_random();
			index = data[27:16]; // Upper LCG bits vary more
			data = next_random();
			model_mem[index] = data;
			written.push_back(index);
			queue_write({1'b0, index}, data);
		end
		// Size register of p1 aliases memory index 0xd00 in its low bits
		data = next_random();
		model_mem[12'hd00] = data;
		written.push_back(12'hd00);
		queue_write(13'h0d00, data);
		queue_write(copro_addr(bus_pkg::unit_size_p1), 32'h0020_0028);
		foreach (written[i])
			push_step(1, 4'h0, 4'h0, 1'b0, 1'b0, {1'b0, written[i]}, '0, 1'b1,
				model_mem[written[i]]);
	endfunction

	function automatic void build_game_rows();
		queue_read(bus_pkg::unit_pos_p1, 32'h0160_0064); // x 352, y 100
		queue_read(bus_pkg::unit_pos_p2, 32'h02a9_0064); // x 681, y 100
		queue_read(bus_pkg::unit_damage_p1, 32'h0);
		queue_read(bus_pkg::unit_damage_p2, 32'h0);
		queue_read(bus_pkg::unit_attack_p1, 32'h0000_0200); // Idle, facing right
		queue_read(bus_pkg::unit_attack_p2, 32'h0);
		queue_read(bus_pkg::unit_size_p1, 32'h0020_0028);
		queue_read(bus_pkg::unit_size_p2, 32'h0020_0028);
		queue_read(bus_pkg::unit_coll_p1, 32'h0);
		queue_read(5'd2, 32'h0); // Unmapped unit
		push_step(1, 4'h9, 4'h6, 1'b0, 1'b0, copro_addr(bus_pkg::unit_pad_p1), '0, 1'b1, 32'h9);
		push_step(1, 4'h9, 4'h6, 1'b0, 1'b0, copro_addr(bus_pkg::unit_pad_p2), '0, 1'b1, 32'h6);

		// Falling with speeds 1, 2, 3
		queue_frames(1, 4'h0, 4'h0);
		queue_read(bus_pkg::unit_pos_p1, 32'h0160_0065);
		queue_frames(1, 4'h0, 4'h0);
		queue_read(bus_pkg::unit_pos_p1, 32'h0160_0067);
		queue_frames(1, 4'h0, 4'h0);
		queue_read(bus_pkg::unit_pos_p1, 32'h0160_006a);
		queue_frames(7, 4'h0, 4'h0);
		queue_read(bus_pkg::unit_coll_p1, 32'h0); // Bottom at 195
		queue_read(bus_pkg::unit_pos_p1, 32'h0160_009b);
		queue_frames(1, 4'h0, 4'h0);
		queue_read(bus_pkg::unit_pos_p1, 32'h0160_00a6); // Bottom at 206
		queue_read(bus_pkg::unit_coll_p1, 32'h1);
		queue_frames(1, 4'h0, 4'h0);
		queue_read(bus_pkg::unit_pos_p1, 32'h0160_00a6);
		queue_read(bus_pkg::unit_pos_p2, 32'h02a9_00a6);

		// Walking, pad bits are left, right, jump, attack
		queue_frames(1, 4'h4, 4'h0);
		queue_read(bus_pkg::unit_pos_p1, 32'h0164_00a6);
		queue_frames(1, 4'hc, 4'h0);
		queue_read(bus_pkg::unit_pos_p1, 32'h0164_00a6);
		queue_frames(1, 4'h0, 4'h0);
		queue_read(bus_pkg::unit_pos_p1, 32'h0164_00a6);
		queue_frames(69, 4'h4, 4'h0);
		queue_read(bus_pkg::unit_pos_p1, 32'h0278_00a6); // x 632, reach covers 681

		// Attack by p1, struck on its first active frame
		queue_frames(1, 4'h1, 4'h0);
		queue_read(bus_pkg::unit_attack_p1, 32'h0000_0606);
		queue_frames(1, 4'h4, 4'h0);
		queue_read(bus_pkg::unit_damage_p2, 32'h7);
		queue_read(bus_pkg::unit_attack_p1, 32'h0000_0705);
		queue_read(bus_pkg::unit_pos_p2, 32'h02a9_00a6); // Knock waits for next frame
		queue_frames(1, 4'h4, 4'h0);
		queue_read(bus_pkg::unit_pos_p2, 32'h02b9_00a6);
		queue_read(bus_pkg::unit_pos_p1, 32'h0278_00a6); // Frozen
		queue_frames(3, 4'h4, 4'h0);
		queue_read(bus_pkg::unit_attack_p1, 32'h0000_0701);
		queue_read(bus_pkg::unit_pos_p1, 32'h0278_00a6);
		queue_frames(1, 4'h0, 4'h0);
		queue_read(bus_pkg::unit_attack_p1, 32'h0000_0200);
		queue_read(bus_pkg::unit_damage_p1, 32'h0);

		// p2 walks off the right stage edge at 804
		queue_frames(26, 4'h0, 4'h4);
		queue_read(bus_pkg::unit_coll_p2, 32'h1);
		queue_frames(1, 4'h0, 4'h4);
		queue_read(bus_pkg::unit_coll_p2, 32'h2);
		queue_read(bus_pkg::unit_pos_p2, 32'h0325_00a6);

		// Jump, then a taller box reaches the stage again
		queue_frames(1, 4'h2, 4'h0);
		queue_read(bus_pkg::unit_pos_p1, 32'h0278_009a);
		queue_read(bus_pkg::unit_coll_p1, 32'h0);
		queue_write(copro_addr(bus_pkg::unit_size_p1), 32'h0020_0032);
		queue_read(bus_pkg::unit_coll_p1, 32'h1); // Bottom at 204
		queue_read(bus_pkg::unit_size_p1, 32'h0020_0032);
	endfunction

	task automatic compare_word(input string name, input bus_pkg::word_t expected,
		input bus_pkg::word_t actual);
		if (actual !== expected) begin
			$display("ERROR %s expected %h actual %h", name, expected, actual);
			$display("Checks failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic apply_step(input step_t s);
		for (int n = 0; n < int'(s.count); n++) begin
			pad_p1 = s.pad1;
			pad_p2 = s.pad2;
			address = bus_pkg::mmio_addr_t'(s.address);
			write_data = s.data;
			write = s.write;
			frame = s.frame;
			@(negedge clock);
			if (s.frame) begin
				frame = 1'b0; // Pulse lasts one cycle
				@(negedge clock);
			end
		end
		if (s.check)
			compare_word("read_data", s.expected, read_data);
	endtask

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout, the table did not finish within %0d cycles", cycle_limit);
			$display("Checks failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	initial begin
		reset = 1'b1;
		address = '0;
		write_data = '0;
		write = 1'b0;
		frame = 1'b0;
		pad_p1 = '0;
		pad_p2 = '0;
		random_state = 32'h7d3d5ef7;
		table_cycles = 0;
		cycle_count = 0;
		cycle_limit = 0;
		build_memory_rows();
		build_game_rows();
		cycle_limit = table_cycles * 4 + 200;
		repeat (16) @(negedge clock);
		reset = 1'b0;
		foreach (steps[i])
			apply_step(steps[i]);
		$display("All checks passed");
		$finish;
	end

endmodule

// File: mmio.f
verilog/game_pkg.sv
verilog/bus_pkg.sv
verilog/physics_coprocessor.sv
verilog/stage_collision.sv
verilog/attack_coprocessor.sv
verilog/data_memory.sv
verilog/mmio.sv
test/mmio_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP := mmio_tb
FILE_LIST := mmio.f
BUILD_DIR := obj_dir
SIM := $(BUILD_DIR)/V$(TOP)
LOG := sim.log
SOURCES := $(shell cat $(FILE_LIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM)
	-./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
